// ==== compile.f ====
design/adder_regs_pkg.sv
design/reg_bus_if.sv
design/ocl_slave_ctrl.sv
design/operand_regs.sv
design/vled_mask.sv
design/tick_counter.sv
design/cl_adder_top.sv
testbench/tb_cl_adder.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the AXI-Lite register block testbench with Verilator.
# The exit status is the simulator's own: nonzero after a $fatal.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_cl_adder -f compile.f -o sim_tb_cl_adder
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit "$build_status"
fi

./obj_dir/sim_tb_cl_adder
run_status=$?
if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit "$run_status"
fi

exit 0

// ==== testbench/tb_cl_adder.sv ====
// Testbench for the AXI-Lite adder register block
// LFSR-driven reads and writes checked against a register model

module tb_cl_adder import adder_regs_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 40;
  localparam int N_PAIRS    = 40;
  localparam int N_UNMAPPED = 8;
  localparam int N_LED      = 12;
  localparam int N_CNT      = 8;
  // Rough bus transaction count of all tests
  localparam int TXN_COUNT  = N_PAIRS * 5 + N_UNMAPPED * 2 + N_LED * 2 + N_CNT * 7 + 60;

  logic              clk_main_a0;
  logic              rst_main_n_sync;
  logic              awvalid;
  logic [ADDR_W-1:0] awaddr;
  logic              awready;
  logic              wvalid;
  logic [DATA_W-1:0] wdata;
  logic              wready;
  logic              bvalid;
  logic [1:0]        bresp;
  logic              bready;
  logic              arvalid;
  logic [ADDR_W-1:0] araddr;
  logic              arready;
  logic              rvalid;
  logic [DATA_W-1:0] rdata;
  logic [1:0]        rresp;
  logic              rready;
  logic [15:0]       vdip;
  logic [15:0]       vled;

  // LFSR state
  logic [15:0] lfsr_q = 16'd31886;

  // Register model
  logic [31:0] x_m;
  logic [31:0] y_m;
  logic [31:0] ctrl_m;
  logic [31:0] load_m;
  logic [31:0] wmark_m;
  logic [31:0] cnt_m;

  cl_adder_top #(.CNT_W(CNT_W_DEF), .LED_W(LED_W_DEF)) u_cl_adder_top (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .vdip            (vdip),
    .vled            (vled)
  );

  initial begin
    clk_main_a0 = 1'b0;
    forever #(CLK_PERIOD / 2) clk_main_a0 = ~clk_main_a0;
  end

  // Feedback taps at 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Random address that misses every mapped register
  function automatic logic [31:0] unmapped_addr();
    logic [31:0] a;
    a = rand_bits(32);
    if (a <= CNT_STATUS_ADDR && a[1:0] == 2'b00) begin
      a = a + 32'h0000_1000;
    end
    return a;
  endfunction

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s expected 0x%08h, got 0x%08h",
               $time, name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_main_a0);
  endtask

  // ----------------------------------------
  // Bus tasks called on a falling edge
  // ----------------------------------------
  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    int delay;
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    // awready only moves on rising edges
    while (!awready) @(negedge clk_main_a0);
    @(negedge clk_main_a0);
    awvalid = 1'b0;
    while (!wready) @(negedge clk_main_a0);
    @(negedge clk_main_a0);
    wvalid = 1'b0;
    while (!bvalid) @(negedge clk_main_a0);
    check_equal("bresp", 32'(OKAY_RESP), 32'(bresp));
    // Response must hold under back-pressure
    delay = rand_bits(2);
    repeat (delay) begin
      @(negedge clk_main_a0);
      check_equal("bvalid", 32'd1, 32'(bvalid));
    end
    bready = 1'b1;
    @(negedge clk_main_a0);
    bready = 1'b0;
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
    int delay;
    arvalid = 1'b1;
    araddr  = addr;
    while (!arready) @(negedge clk_main_a0);
    @(negedge clk_main_a0);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk_main_a0);
    data = rdata;
    check_equal("rresp", 32'(OKAY_RESP), 32'(rresp));
    delay = rand_bits(2);
    repeat (delay) begin
      @(negedge clk_main_a0);
      check_equal("rvalid", 32'd1, 32'(rvalid));
      check_equal("rdata", data, rdata);
    end
    rready = 1'b1;
    @(negedge clk_main_a0);
    rready = 1'b0;
  endtask

  // Every readable register against the model while the counter is stopped
  task automatic compare_all_regs();
    logic [31:0] rd;
    read_reg(X_ADDR, rd);
    check_equal("x", x_m, rd);
    read_reg(Y_ADDR, rd);
    check_equal("y", y_m, rd);
    read_reg(SUM_ADDR, rd);
    check_equal("sum", x_m + y_m, rd);
    read_reg(VLED_ADDR, rd);
    check_equal("vled_read", {16'h0, x_m[15:0]}, rd);
    read_reg(CNT_CTRL_ADDR, rd);
    check_equal("cnt_ctrl", ctrl_m, rd);
    read_reg(CNT_LOAD_ADDR, rd);
    check_equal("cnt_load", load_m, rd);
    read_reg(CNT_WMARK_ADDR, rd);
    check_equal("cnt_wmark", wmark_m, rd);
    read_reg(CNT_VALUE_ADDR, rd);
    check_equal("cnt_value", cnt_m, rd);
  endtask

  // Watchdog
  initial begin
    #(TXN_COUNT * 40 * CLK_PERIOD);
    $display("Watchdog: test did not finish within %0d cycles", TXN_COUNT * 40);
    $display("SIMULATION FAILED");
    $fatal(1, "Watchdog timeout");
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] wd;
    logic [15:0] dip_v;
    logic [15:0] load_v;
    logic [15:0] wmark_v;
    logic [15:0] prev_v;
    rst_main_n_sync = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    vdip    = '0;
    x_m     = '0;
    y_m     = '0;
    ctrl_m  = '0;
    load_m  = '0;
    wmark_m = '0;
    cnt_m   = '0;

    // Reset over three rising edges
    repeat (3) @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;
    @(negedge clk_main_a0);

    // Idle state out of reset
    check_equal("awready", 32'd1, 32'(awready));
    check_equal("arready", 32'd1, 32'(arready));
    check_equal("bvalid", 32'd0, 32'(bvalid));
    check_equal("rvalid", 32'd0, 32'(rvalid));
    check_equal("vled", 32'd0, 32'(vled));

    // ----------------------------------------
    // Operands and sum
    // ----------------------------------------
    for (int i = 0; i < N_PAIRS; i++) begin
      x_m = rand_bits(32);
      y_m = rand_bits(32);
      write_reg(X_ADDR, x_m);
      write_reg(Y_ADDR, y_m);
      read_reg(X_ADDR, rd);
      check_equal("x", x_m, rd);
      read_reg(Y_ADDR, rd);
      check_equal("y", y_m, rd);
      read_reg(SUM_ADDR, rd);
      check_equal("sum", x_m + y_m, rd);
    end

    // Counter registers with enable and pulse bits kept clear
    wd = rand_bits(32) & 32'hFFFF_FFF2;
    write_reg(CNT_CTRL_ADDR, wd);
    ctrl_m = wd & 32'h0000_FF03;
    wd = rand_bits(32);
    write_reg(CNT_LOAD_ADDR, wd);
    load_m = {16'h0, wd[15:0]};
    wd = rand_bits(32);
    write_reg(CNT_WMARK_ADDR, wd);
    wmark_m = {16'h0, wd[15:0]};
    compare_all_regs();

    // Unmapped reads and then writes that must change nothing
    for (int i = 0; i < N_UNMAPPED; i++) begin
      read_reg(unmapped_addr(), rd);
      check_equal("unmapped_read", UNIMPL_VALUE, rd);
    end
    write_reg(SUM_ADDR, rand_bits(32));
    write_reg(unmapped_addr(), rand_bits(32));
    compare_all_regs();

    // ----------------------------------------
    // Virtual LEDs
    // ----------------------------------------
    for (int i = 0; i < N_LED; i++) begin
      dip_v = 16'(rand_bits(16));
      vdip  = dip_v;
      x_m   = rand_bits(32);
      write_reg(X_ADDR, x_m);
      wait_cycles(4);
      check_equal("vled", 32'(x_m[15:0] & dip_v), 32'(vled));
      read_reg(VLED_ADDR, rd);
      check_equal("vled_read", {16'h0, x_m[15:0]}, rd);
    end

    // ----------------------------------------
    // Stopped counter load, clear and watermark
    // ----------------------------------------
    write_reg(CNT_CTRL_ADDR, 32'h0);
    ctrl_m = '0;
    for (int i = 0; i < N_CNT; i++) begin
      load_v  = 16'(rand_bits(16));
      // First pass hits the equal case
      wmark_v = (i == 0) ? load_v : 16'(rand_bits(16));
      write_reg(CNT_LOAD_ADDR, 32'(load_v));
      load_m = 32'(load_v);
      write_reg(CNT_WMARK_ADDR, 32'(wmark_v));
      wmark_m = 32'(wmark_v);
      write_reg(CNT_CTRL_ADDR, 32'h0000_0008);
      cnt_m = load_m;
      read_reg(CNT_VALUE_ADDR, rd);
      check_equal("cnt_value", cnt_m, rd);
      read_reg(CNT_STATUS_ADDR, rd);
      check_equal("ge_watermark", 32'(cnt_m >= wmark_m), 32'(rd[1]));
      write_reg(CNT_CTRL_ADDR, 32'h0000_0004);
      cnt_m = '0;
      read_reg(CNT_VALUE_ADDR, rd);
      check_equal("cnt_value", cnt_m, rd);
    end

    // Running at one count per cycle from a clear
    write_reg(CNT_CTRL_ADDR, 32'h0000_0005);
    prev_v = '0;
    for (int i = 0; i < 10; i++) begin
      read_reg(CNT_VALUE_ADDR, rd);
      check_equal("cnt_nondecreasing", 32'd1, 32'(rd[15:0] >= prev_v));
      prev_v = rd[15:0];
    end
    check_equal("cnt_running", 32'd1, 32'(prev_v != 16'h0));

    // One-shot stops at the maximum
    write_reg(CNT_CTRL_ADDR, 32'h0);
    write_reg(CNT_LOAD_ADDR, 32'h0000_FFFE);
    write_reg(CNT_CTRL_ADDR, 32'h0000_0008);
    read_reg(CNT_VALUE_ADDR, rd);
    check_equal("cnt_value", 32'h0000_FFFE, rd);
    write_reg(CNT_CTRL_ADDR, 32'h0000_0003);
    wait_cycles(10);
    for (int i = 0; i < 5; i++) begin
      read_reg(CNT_VALUE_ADDR, rd);
      check_equal("cnt_oneshot", 32'h0000_FFFF, rd);
      wait_cycles(int'(rand_bits(2)));
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== design/cl_adder_top.sv ====
// AXI-Lite adder register block, top level
// Connects the AXI-Lite control block to the operand,
// virtual LED and event counter blocks over the register bus

module cl_adder_top import adder_regs_pkg::*; #(
  parameter int CNT_W = CNT_W_DEF,
  parameter int LED_W = LED_W_DEF
) (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  // Write address, data and response
  input  logic              awvalid,
  input  logic [ADDR_W-1:0] awaddr,
  output logic              awready,
  input  logic              wvalid,
  input  logic [DATA_W-1:0] wdata,
  output logic              wready,
  output logic              bvalid,
  output logic [1:0]        bresp,
  input  logic              bready,
  // Read address and data
  input  logic              arvalid,
  input  logic [ADDR_W-1:0] araddr,
  output logic              arready,
  output logic              rvalid,
  output logic [DATA_W-1:0] rdata,
  output logic [1:0]        rresp,
  input  logic              rready,
  // Virtual switches and LEDs
  input  logic [LED_W-1:0]  vdip,
  output logic [LED_W-1:0]  vled
);

  reg_bus_if #(.CNT_W(CNT_W), .LED_W(LED_W)) u_bus ();

  ocl_slave_ctrl u_ocl_slave_ctrl (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .bus             (u_bus.ctrl)
  );

  operand_regs u_operand_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .bus             (u_bus.operands)
  );

  vled_mask #(.LED_W(LED_W)) u_vled_mask (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .vdip            (vdip),
    .vled            (vled),
    .bus             (u_bus.leds)
  );

  tick_counter #(.CNT_W(CNT_W)) u_tick_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .bus             (u_bus.counter)
  );

endmodule

// ==== design/tick_counter.sv ====
// Tick-prescaled event counter
// Control, load and watermark registers on the register bus.
// Clear beats load beats counting; one-shot holds at maximum.

module tick_counter import adder_regs_pkg::*; #(
  parameter int CNT_W = CNT_W_DEF
) (
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  reg_bus_if.counter bus
);

  localparam logic [CNT_W-1:0] CNT_MAX = '1;

  cnt_ctrl_u         ctrl_wr;
  cnt_ctrl_u         ctrl_q;
  logic              ctrl_hit;
  logic              clr_q;
  logic              ld_q;
  logic [CNT_W-1:0]  load_q;
  logic [CNT_W-1:0]  wmark_q;
  logic [CNT_W-1:0]  cnt_q;
  logic [TICK_W-1:0] tick_cnt_q;
  logic              tick;
  logic              ge_wmark;

  // Incoming control word viewed by field below
  assign ctrl_wr.raw = bus.wr_data;
  assign ctrl_hit    = bus.wr_en && (bus.wr_sel == SEL_CNT_CTRL);

  // ----------------------------------------
  // Register writes
  // ----------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ctrl_q  <= '0;
      clr_q   <= 1'b0;
      ld_q    <= 1'b0;
      load_q  <= '0;
      wmark_q <= '0;
    end else begin
      if (ctrl_hit) begin
        ctrl_q.raw <= ctrl_wr.raw & CNT_CTRL_KEEP_MASK;
      end
      // Pulses act on the following edge
      clr_q <= ctrl_hit && ctrl_wr.f.clear;
      ld_q  <= ctrl_hit && ctrl_wr.f.load;
      if (bus.wr_en && bus.wr_sel == SEL_CNT_LOAD) begin
        load_q <= bus.wr_data[CNT_W-1:0];
      end
      if (bus.wr_en && bus.wr_sel == SEL_CNT_WMARK) begin
        wmark_q <= bus.wr_data[CNT_W-1:0];
      end
    end
  end

  // Prescaler wraps after tick_value
  assign tick     = (tick_cnt_q >= ctrl_q.f.tick_value);
  assign ge_wmark = (cnt_q >= wmark_q);

  // ----------------------------------------
  // Prescaler and counter
  // ----------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tick_cnt_q <= '0;
      cnt_q      <= '0;
    end else begin
      if (clr_q) begin
        tick_cnt_q <= '0;
      end else if (ctrl_q.f.enable) begin
        tick_cnt_q <= tick ? '0 : tick_cnt_q + 1'b1;
      end
      if (clr_q) begin
        cnt_q <= '0;
      end else if (ld_q) begin
        cnt_q <= load_q;
      end else if (ctrl_q.f.enable && tick && !(ctrl_q.f.oneshot && cnt_q == CNT_MAX)) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign bus.cnt_ctrl_val  = ctrl_q.raw;
  assign bus.cnt_load_val  = load_q;
  assign bus.cnt_wmark_val = wmark_q;
  assign bus.cnt_value     = cnt_q;

  // Status word
  always_comb begin
    bus.cnt_status_val              = '0;
    bus.cnt_status_val[8 +: TICK_W] = tick_cnt_q;
    bus.cnt_status_val[1]           = ge_wmark;
    bus.cnt_status_val[0]           = tick;
  end

  // One-shot count never wraps back down without a clear or load
  a_oneshot_no_wrap: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (ctrl_q.f.oneshot && !clr_q && !ld_q) |=> (cnt_q >= $past(cnt_q))
  );

endmodule

// ==== design/vled_mask.sv ====
// Virtual LED block
// Shadows the low bits of X and drives the LED outputs
// masked by the two-flop synchronized DIP switches

module vled_mask import adder_regs_pkg::*; #(
  parameter int LED_W = LED_W_DEF
) (
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  logic [LED_W-1:0] vdip,
  output logic [LED_W-1:0] vled,
  reg_bus_if.leds          bus
);

  logic [LED_W-1:0] vdip_q1;
  logic [LED_W-1:0] vdip_q2;
  logic [LED_W-1:0] shadow_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q1  <= '0;
      vdip_q2  <= '0;
      shadow_q <= '0;
      vled     <= '0;
    end else begin
      // DIP synchronizer
      vdip_q1  <= vdip;
      vdip_q2  <= vdip_q1;
      // Follows X one edge late
      shadow_q <= bus.x_val[LED_W-1:0];
      // Masked output flop
      vled     <= shadow_q & vdip_q2;
    end
  end

  // Read-back is the shadow, not the masked output
  assign bus.vled_val = shadow_q;

endmodule

// ==== design/operand_regs.sv ====
// Operand registers
// X and Y written over the register bus, with their
// 32-bit wrapping sum presented for read-back

module operand_regs import adder_regs_pkg::*; (
  input  logic        clk_main_a0,
  input  logic        rst_main_n_sync,
  reg_bus_if.operands bus
);

  logic [DATA_W-1:0] x_q;
  logic [DATA_W-1:0] y_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      x_q <= '0;
      y_q <= '0;
    end else if (bus.wr_en) begin
      // Only X and Y are writable here
      if (bus.wr_sel == SEL_X) begin
        x_q <= bus.wr_data;
      end
      if (bus.wr_sel == SEL_Y) begin
        y_q <= bus.wr_data;
      end
    end
  end

  assign bus.x_val = x_q;
  assign bus.y_val = y_q;

  // Carry out dropped
  assign bus.sum_val = x_q + y_q;

endmodule

// ==== design/ocl_slave_ctrl.sv ====
// AXI-Lite slave control
// Single-beat reads and writes with one outstanding each way.
// Decodes addresses into register selects and muxes read data.

module ocl_slave_ctrl import adder_regs_pkg::*; (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic              awvalid,
  input  logic [ADDR_W-1:0] awaddr,
  output logic              awready,
  input  logic              wvalid,
  input  logic [DATA_W-1:0] wdata,
  output logic              wready,
  output logic              bvalid,
  output logic [1:0]        bresp,
  input  logic              bready,
  input  logic              arvalid,
  input  logic [ADDR_W-1:0] araddr,
  output logic              arready,
  output logic              rvalid,
  output logic [DATA_W-1:0] rdata,
  output logic [1:0]        rresp,
  input  logic              rready,
  reg_bus_if.ctrl           bus
);

  logic              wr_active;
  reg_sel_e          wr_sel_q;
  logic              ar_pend;
  logic [ADDR_W-1:0] araddr_q;
  reg_sel_e          rd_sel;
  logic [DATA_W-1:0] rd_word;

  // Full-word address match
  function automatic reg_sel_e decode_addr(input logic [ADDR_W-1:0] addr);
    case (addr)
      X_ADDR:          return SEL_X;
      Y_ADDR:          return SEL_Y;
      SUM_ADDR:        return SEL_SUM;
      VLED_ADDR:       return SEL_VLED;
      CNT_CTRL_ADDR:   return SEL_CNT_CTRL;
      CNT_LOAD_ADDR:   return SEL_CNT_LOAD;
      CNT_WMARK_ADDR:  return SEL_CNT_WMARK;
      CNT_VALUE_ADDR:  return SEL_CNT_VALUE;
      CNT_STATUS_ADDR: return SEL_CNT_STATUS;
      default:         return SEL_NONE;
    endcase
  endfunction

  // ----------------------------------------
  // Write channel
  // ----------------------------------------
  // Active from aw transfer until b transfer
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
      wr_sel_q  <= SEL_NONE;
      bvalid    <= 1'b0;
    end else begin
      if (awvalid && awready) begin
        wr_active <= 1'b1;
        wr_sel_q  <= decode_addr(awaddr);
      end else if (bvalid && bready) begin
        wr_active <= 1'b0;
      end
      // Response one edge after the data beat
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end else if (wready) begin
        bvalid <= 1'b1;
      end
    end
  end

  assign awready = !wr_active;
  assign wready  = wr_active && wvalid;
  assign bresp   = OKAY_RESP;

  // Register update on the data beat
  assign bus.wr_en   = wready;
  assign bus.wr_sel  = wr_sel_q;
  assign bus.wr_data = wdata;

  // ----------------------------------------
  // Read channel
  // ----------------------------------------
  assign arready = !ar_pend && !rvalid;
  assign rd_sel  = decode_addr(araddr_q);

  always_comb begin
    case (rd_sel)
      SEL_X:          rd_word = bus.x_val;
      SEL_Y:          rd_word = bus.y_val;
      SEL_SUM:        rd_word = bus.sum_val;
      SEL_VLED:       rd_word = DATA_W'(bus.vled_val);
      SEL_CNT_CTRL:   rd_word = bus.cnt_ctrl_val;
      SEL_CNT_LOAD:   rd_word = DATA_W'(bus.cnt_load_val);
      SEL_CNT_WMARK:  rd_word = DATA_W'(bus.cnt_wmark_val);
      SEL_CNT_VALUE:  rd_word = DATA_W'(bus.cnt_value);
      SEL_CNT_STATUS: rd_word = bus.cnt_status_val;
      default:        rd_word = UNIMPL_VALUE;
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ar_pend  <= 1'b0;
      araddr_q <= '0;
      rvalid   <= 1'b0;
      rdata    <= '0;
    end else begin
      ar_pend <= arvalid && arready;
      if (arvalid && arready) begin
        araddr_q <= araddr;
      end
      // Data held until taken, then cleared
      if (rvalid && rready) begin
        rvalid <= 1'b0;
        rdata  <= '0;
      end else if (ar_pend) begin
        rvalid <= 1'b1;
        rdata  <= rd_word;
      end
    end
  end

  assign rresp = OKAY_RESP;

  // No second data beat while the write response waits
  a_wready_no_beat_in_resp: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    wready |-> !bvalid
  );

endmodule

// ==== design/reg_bus_if.sv ====
// Internal register bus
// One write port from the AXI-Lite control block and the
// read-back values of each datapath block

interface reg_bus_if import adder_regs_pkg::*; #(
  parameter int CNT_W = CNT_W_DEF,
  parameter int LED_W = LED_W_DEF
) ();

  // Write side, one-cycle pulse per accepted beat
  logic              wr_en;
  reg_sel_e          wr_sel;
  logic [DATA_W-1:0] wr_data;

  // Operand block
  logic [DATA_W-1:0] x_val;
  logic [DATA_W-1:0] y_val;
  logic [DATA_W-1:0] sum_val;

  // LED shadow, unmasked
  logic [LED_W-1:0]  vled_val;

  // Counter block
  logic [DATA_W-1:0] cnt_ctrl_val;
  logic [CNT_W-1:0]  cnt_load_val;
  logic [CNT_W-1:0]  cnt_wmark_val;
  logic [CNT_W-1:0]  cnt_value;
  logic [DATA_W-1:0] cnt_status_val;

  modport ctrl (
    output wr_en, wr_sel, wr_data,
    input  x_val, y_val, sum_val, vled_val,
    input  cnt_ctrl_val, cnt_load_val, cnt_wmark_val, cnt_value, cnt_status_val
  );

  modport operands (input wr_en, wr_sel, wr_data, output x_val, y_val, sum_val);

  modport leds (input x_val, output vled_val);

  modport counter (
    input  wr_en, wr_sel, wr_data,
    output cnt_ctrl_val, cnt_load_val, cnt_wmark_val, cnt_value, cnt_status_val
  );

endinterface

// ==== design/adder_regs_pkg.sv ====
// Register block definitions
// Bus widths, address map, register select codes and the
// counter control word shared by the AXI-Lite register block

package adder_regs_pkg;

  // Bus widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;

  // Default datapath widths
  localparam int CNT_W_DEF = 16;
  localparam int LED_W_DEF = 16;

  // Prescaler width, matches tick_value field
  localparam int TICK_W = 8;

  // ----------------------------------------
  // Address map, full word match
  // ----------------------------------------
  localparam logic [ADDR_W-1:0] X_ADDR          = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] Y_ADDR          = 32'h0000_0004;
  localparam logic [ADDR_W-1:0] SUM_ADDR        = 32'h0000_0008;
  localparam logic [ADDR_W-1:0] VLED_ADDR       = 32'h0000_000C;
  localparam logic [ADDR_W-1:0] CNT_CTRL_ADDR   = 32'h0000_0010;
  localparam logic [ADDR_W-1:0] CNT_LOAD_ADDR   = 32'h0000_0014;
  localparam logic [ADDR_W-1:0] CNT_WMARK_ADDR  = 32'h0000_0018;
  localparam logic [ADDR_W-1:0] CNT_VALUE_ADDR  = 32'h0000_001C;
  localparam logic [ADDR_W-1:0] CNT_STATUS_ADDR = 32'h0000_0020;

  // Read value for unmapped addresses
  localparam logic [DATA_W-1:0] UNIMPL_VALUE = 32'hDEAD_DEAD;

  // Always OKAY on both response channels
  localparam logic [1:0] OKAY_RESP = 2'b00;

  // Decoded register select
  typedef enum logic [3:0] {
    SEL_NONE,
    SEL_X,
    SEL_Y,
    SEL_SUM,
    SEL_VLED,
    SEL_CNT_CTRL,
    SEL_CNT_LOAD,
    SEL_CNT_WMARK,
    SEL_CNT_VALUE,
    SEL_CNT_STATUS
  } reg_sel_e;

  // Counter control word, raw or by field
  typedef union packed {
    logic [DATA_W-1:0] raw;
    struct packed {
      logic [15:0]       rsvd_hi;
      logic [TICK_W-1:0] tick_value;
      logic [3:0]        rsvd_lo;
      logic              load;
      logic              clear;
      logic              oneshot;
      logic              enable;
    } f;
  } cnt_ctrl_u;

  // Stored control bits, pulses and reserved bits dropped
  localparam logic [DATA_W-1:0] CNT_CTRL_KEEP_MASK = 32'h0000_FF03;

endpackage
